// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module dcache_replay_tb -f sources.f -o dcache_replay_sim

./obj_dir/dcache_replay_sim | tee sim.log

if grep -q "All checks passed" sim.log
then
   exit 0
fi
exit 1

// File: sources.f
src/dcache_replay_pkg.sv
src/replay_req_if.sv
src/cache_mem_if.sv
src/replay_fifo.sv
src/dcache_pipe.sv
src/miss_engine.sv
src/dcache_replay_top.sv
test/dcache_replay_checker.sv
test/dcache_replay_tb.sv

// File: src/cache_mem_if.sv
// Pipeline to miss engine link; fill targets the line of the last accepted read request
`timescale 1ns/1ps
`default_nettype none

interface cache_mem_if;
   import dcache_replay_pkg::*;

   logic                  req_valid;
   logic                  req_write;
   cache_addr_u           req_addr;
   logic [DATA_WIDTH-1:0] req_data;
   logic                  req_ready;
   logic                  busy;
   logic                  fill_valid;
   logic [DATA_WIDTH-1:0] fill_data;

   modport cache_side
   (
      output req_valid, req_write, req_addr, req_data,
      input  req_ready, busy, fill_valid, fill_data
   );

   modport engine_side
   (
      input  req_valid, req_write, req_addr, req_data,
      output req_ready, busy, fill_valid, fill_data
   );

endinterface

`default_nettype wire

// File: src/dcache_pipe.sv
// Direct-mapped, one word per line, write-through without store allocation; misses roll back
`timescale 1ns/1ps
`default_nettype none

module dcache_pipe
(
   input  logic                                     clk_i,
   input  logic                                     rst_n_i,
   replay_req_if.cache_side                         req,
   cache_mem_if.cache_side                          mem,
   output logic                                     resp_valid_o,
   output logic [dcache_replay_pkg::DATA_WIDTH-1:0] resp_data_o
);
   import dcache_replay_pkg::*;

   logic [TAG_WIDTH-1:0]    tag_mem  [2**INDEX_WIDTH];
   logic [DATA_WIDTH-1:0]   data_mem [2**INDEX_WIDTH];
   logic [2**INDEX_WIDTH-1:0] line_valid_q;

   logic                  s1_valid_q;
   logic                  s1_op_q;
   cache_addr_u           s1_addr_q;
   logic [DATA_WIDTH-1:0] s1_data_q;

   logic                  s2_valid_q;
   logic                  s2_op_q;
   cache_addr_u           s2_addr_q;
   logic [DATA_WIDTH-1:0] s2_data_q;
   logic [TAG_WIDTH-1:0]  s2_tag_q;
   logic                  s2_line_v_q;
   logic [DATA_WIDTH-1:0] s2_rdata_q;

   cache_addr_u           fill_addr_q;
   logic                  accept;
   logic                  s2_store;
   logic                  s2_hit;
   logic                  s2_done;
   logic                  store_wr;

   assign req.ready = ~mem.busy & ~mem.fill_valid;
   assign accept    = req.valid & req.ready;

   // Stage 2 judgement
   assign s2_store = (s2_op_q == OP_STORE);
   assign s2_hit   = s2_line_v_q & (s2_tag_q == s2_addr_q.fields.tag);
   assign s2_done  = s2_valid_q & (s2_store ? mem.req_ready : s2_hit);
   assign store_wr = s2_valid_q & s2_store & s2_hit & mem.req_ready;

   assign mem.req_valid = s2_valid_q & (s2_store | ~s2_hit);
   assign mem.req_write = s2_store;
   assign mem.req_addr  = s2_addr_q;
   assign mem.req_data  = s2_data_q;

   assign resp_valid_o = s2_done;
   assign resp_data_o  = s2_store ? '0 : s2_rdata_q;
   assign req.commit   = s2_done;
   assign req.rollback = s2_valid_q & ~s2_done;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         s1_valid_q   <= 1'b0;
         s2_valid_q   <= 1'b0;
         line_valid_q <= '0;
      end
      else
      begin
         // A failing item flushes everything younger
         s1_valid_q <= accept & ~req.rollback;
         s2_valid_q <= s1_valid_q & ~req.rollback;
         if (mem.fill_valid)
            line_valid_q[fill_addr_q.fields.index] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         s1_op_q   <= req.op;
         s1_addr_q <= req.addr;
         s1_data_q <= req.data;
      end
      s2_op_q     <= s1_op_q;
      s2_addr_q   <= s1_addr_q;
      s2_data_q   <= s1_data_q;
      s2_tag_q    <= tag_mem[s1_addr_q.fields.index];
      s2_line_v_q <= line_valid_q[s1_addr_q.fields.index];
      // Forward a store hit landing on the line being read
      if (store_wr && (s2_addr_q.fields.index == s1_addr_q.fields.index))
         s2_rdata_q <= s2_data_q;
      else
         s2_rdata_q <= data_mem[s1_addr_q.fields.index];
   end

   // Fills only land while both stages are empty
   always_ff @(posedge clk_i)
   begin
      if (mem.fill_valid)
      begin
         tag_mem[fill_addr_q.fields.index]  <= fill_addr_q.fields.tag;
         data_mem[fill_addr_q.fields.index] <= mem.fill_data;
      end
      else if (store_wr)
         data_mem[s2_addr_q.fields.index] <= s2_data_q;
      if (mem.req_valid && mem.req_ready && !s2_store)
         fill_addr_q <= s2_addr_q;
   end

endmodule

`default_nettype wire

// File: src/dcache_replay_pkg.sv
// Shared cache geometry and opcodes; addresses must be word aligned and fit ADDR_WIDTH bits
`default_nettype none

package dcache_replay_pkg;

   // Byte address and data word
   localparam int ADDR_WIDTH = 16;
   localparam int DATA_WIDTH = 64;

   // Address fields, one 64-bit word per line
   localparam int OFFSET_WIDTH = 3;
   localparam int INDEX_WIDTH  = 4;
   localparam int TAG_WIDTH    = 9;

   // Replay FIFO entries
   localparam int FIFO_DEPTH = 8;

   // Request opcodes
   localparam logic OP_LOAD  = 1'b0;
   localparam logic OP_STORE = 1'b1;

   // One address word, seen raw or split into cache fields
   typedef union packed
   {
      logic [ADDR_WIDTH-1:0] raw;
      struct packed
      {
         logic [TAG_WIDTH-1:0]    tag;
         logic [INDEX_WIDTH-1:0]  index;
         logic [OFFSET_WIDTH-1:0] offset;
      } fields;
   } cache_addr_u;

endpackage

`default_nettype wire

// File: src/dcache_replay_top.sv
// Replay cache top; responses come in request order, stores answer zero, addresses word aligned
`timescale 1ns/1ps
`default_nettype none

module dcache_replay_top
(
   input  logic                                     clk_i,
   input  logic                                     rst_n_i,
   input  logic                                     req_valid_i,
   output logic                                     req_ready_o,
   input  logic                                     req_op_i,
   input  logic [dcache_replay_pkg::ADDR_WIDTH-1:0] req_addr_i,
   input  logic [dcache_replay_pkg::DATA_WIDTH-1:0] req_data_i,
   output logic                                     resp_valid_o,
   output logic [dcache_replay_pkg::DATA_WIDTH-1:0] resp_data_o,
   output logic                                     mem_cmd_valid_o,
   input  logic                                     mem_cmd_ready_i,
   output logic                                     mem_cmd_write_o,
   output logic [dcache_replay_pkg::ADDR_WIDTH-1:0] mem_cmd_addr_o,
   output logic [dcache_replay_pkg::DATA_WIDTH-1:0] mem_cmd_data_o,
   input  logic                                     mem_resp_valid_i,
   output logic                                     mem_resp_ready_o,
   input  logic [dcache_replay_pkg::DATA_WIDTH-1:0] mem_resp_data_i
);

   replay_req_if req_if ();
   cache_mem_if  mem_if ();

   replay_fifo u_fifo
   (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wr_valid_i (req_valid_i),
      .wr_ready_o (req_ready_o),
      .wr_op_i    (req_op_i),
      .wr_addr_i  (req_addr_i),
      .wr_data_i  (req_data_i),
      .req        (req_if.fifo_side)
   );

   dcache_pipe u_pipe
   (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req          (req_if.cache_side),
      .mem          (mem_if.cache_side),
      .resp_valid_o (resp_valid_o),
      .resp_data_o  (resp_data_o)
   );

   miss_engine u_engine
   (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .mem              (mem_if.engine_side),
      .mem_cmd_valid_o  (mem_cmd_valid_o),
      .mem_cmd_ready_i  (mem_cmd_ready_i),
      .mem_cmd_write_o  (mem_cmd_write_o),
      .mem_cmd_addr_o   (mem_cmd_addr_o),
      .mem_cmd_data_o   (mem_cmd_data_o),
      .mem_resp_valid_i (mem_resp_valid_i),
      .mem_resp_ready_o (mem_resp_ready_o),
      .mem_resp_data_i  (mem_resp_data_i)
   );

endmodule

`default_nettype wire

// File: src/miss_engine.sv
// One outstanding memory command at a time; writes are posted and expect no response
`timescale 1ns/1ps
`default_nettype none

module miss_engine
(
   input  logic                                     clk_i,
   input  logic                                     rst_n_i,
   cache_mem_if.engine_side                         mem,
   output logic                                     mem_cmd_valid_o,
   input  logic                                     mem_cmd_ready_i,
   output logic                                     mem_cmd_write_o,
   output logic [dcache_replay_pkg::ADDR_WIDTH-1:0] mem_cmd_addr_o,
   output logic [dcache_replay_pkg::DATA_WIDTH-1:0] mem_cmd_data_o,
   input  logic                                     mem_resp_valid_i,
   output logic                                     mem_resp_ready_o,
   input  logic [dcache_replay_pkg::DATA_WIDTH-1:0] mem_resp_data_i
);
   import dcache_replay_pkg::*;

   // Idle when neither send nor wait is set
   logic                  send_q;
   logic                  wait_q;
   logic                  cmd_write_q;
   cache_addr_u           cmd_addr_q;
   logic [DATA_WIDTH-1:0] cmd_data_q;
   logic                  fill_valid_q;
   logic [DATA_WIDTH-1:0] fill_data_q;
   logic                  req_fire;
   logic                  cmd_fire;
   logic                  resp_fire;

   assign mem.req_ready = ~send_q & ~wait_q;
   assign mem.busy      = send_q | wait_q;
   assign req_fire      = mem.req_valid & mem.req_ready;
   assign cmd_fire      = send_q & mem_cmd_ready_i;
   assign resp_fire     = wait_q & mem_resp_valid_i;

   assign mem_cmd_valid_o  = send_q;
   assign mem_cmd_write_o  = cmd_write_q;
   assign mem_cmd_addr_o   = cmd_addr_q.raw;
   assign mem_cmd_data_o   = cmd_data_q;
   assign mem_resp_ready_o = wait_q;
   assign mem.fill_valid   = fill_valid_q;
   assign mem.fill_data    = fill_data_q;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         send_q       <= 1'b0;
         wait_q       <= 1'b0;
         fill_valid_q <= 1'b0;
      end
      else
      begin
         fill_valid_q <= resp_fire;
         if (req_fire)
            send_q <= 1'b1;
         else if (cmd_fire)
         begin
            send_q <= 1'b0;
            // Only reads wait for data
            wait_q <= ~cmd_write_q;
         end
         else if (resp_fire)
            wait_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (req_fire)
      begin
         cmd_write_q <= mem.req_write;
         cmd_addr_q  <= mem.req_addr;
         cmd_data_q  <= mem.req_data;
      end
      if (resp_fire)
         fill_data_q <= mem_resp_data_i;
   end

endmodule

`default_nettype wire

// File: src/replay_fifo.sv
// Rollback FIFO; entries stay until committed, so a full FIFO blocks writes until commits arrive
`timescale 1ns/1ps
`default_nettype none

module replay_fifo
(
   input  logic                                     clk_i,
   input  logic                                     rst_n_i,
   input  logic                                     wr_valid_i,
   output logic                                     wr_ready_o,
   input  logic                                     wr_op_i,
   input  dcache_replay_pkg::cache_addr_u           wr_addr_i,
   input  logic [dcache_replay_pkg::DATA_WIDTH-1:0] wr_data_i,
   replay_req_if.fifo_side                          req
);
   import dcache_replay_pkg::*;

   logic                  op_mem   [FIFO_DEPTH];
   cache_addr_u           addr_mem [FIFO_DEPTH];
   logic [DATA_WIDTH-1:0] data_mem [FIFO_DEPTH];

   // Pointers carry one extra wrap bit
   logic [$clog2(FIFO_DEPTH):0] wr_ptr_q;
   logic [$clog2(FIFO_DEPTH):0] rd_ptr_q;
   logic [$clog2(FIFO_DEPTH):0] cm_ptr_q;
   logic [$clog2(FIFO_DEPTH):0] cm_ptr_next;
   logic [$clog2(FIFO_DEPTH):0] count_q;
   logic                        wr_fire;
   logic                        rd_fire;

   assign wr_ready_o  = (count_q < FIFO_DEPTH);
   assign wr_fire     = wr_valid_i & wr_ready_o;
   assign rd_fire     = req.valid & req.ready;
   assign cm_ptr_next = req.commit ? cm_ptr_q + 1'b1 : cm_ptr_q;

   // Unread entries lie between read and write pointers
   assign req.valid = (rd_ptr_q != wr_ptr_q);
   assign req.op    = op_mem[rd_ptr_q[$clog2(FIFO_DEPTH)-1:0]];
   assign req.addr  = addr_mem[rd_ptr_q[$clog2(FIFO_DEPTH)-1:0]];
   assign req.data  = data_mem[rd_ptr_q[$clog2(FIFO_DEPTH)-1:0]];

   always_ff @(posedge clk_i)
   begin
      if (wr_fire)
      begin
         op_mem[wr_ptr_q[$clog2(FIFO_DEPTH)-1:0]]   <= wr_op_i;
         addr_mem[wr_ptr_q[$clog2(FIFO_DEPTH)-1:0]] <= wr_addr_i;
         data_mem[wr_ptr_q[$clog2(FIFO_DEPTH)-1:0]] <= wr_data_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cm_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (wr_fire)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         cm_ptr_q <= cm_ptr_next;
         // Rewind wins over a read in the same cycle
         if (req.rollback)
            rd_ptr_q <= cm_ptr_next;
         else if (rd_fire)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({wr_fire, req.commit})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: src/replay_req_if.sv
// Request path from replay FIFO to cache pipeline; commit is applied before rollback in one cycle
`timescale 1ns/1ps
`default_nettype none

interface replay_req_if;
   import dcache_replay_pkg::*;

   logic                  valid;
   logic                  ready;
   logic                  op;
   cache_addr_u           addr;
   logic [DATA_WIDTH-1:0] data;
   logic                  rollback;
   logic                  commit;

   modport fifo_side (output valid, op, addr, data, input ready, rollback, commit);

   modport cache_side (input valid, op, addr, data, output ready, rollback, commit);

endinterface

`default_nettype wire

// File: test/dcache_replay_checker.sv
// Handshake rules on the cache top; all but the reset rule are off while rst_n_i is low
`timescale 1ns/1ps
`default_nettype none

module dcache_replay_checker
(
   input logic                                     clk_i,
   input logic                                     rst_n_i,
   input logic                                     resp_valid_o,
   input logic                                     mem_cmd_valid_o,
   input logic                                     mem_cmd_ready_i,
   input logic                                     mem_cmd_write_o,
   input logic [dcache_replay_pkg::ADDR_WIDTH-1:0] mem_cmd_addr_o,
   input logic [dcache_replay_pkg::DATA_WIDTH-1:0] mem_cmd_data_o,
   input logic                                     mem_resp_ready_o
);

   int fail_count = 0;

   // A waiting command holds every field
   cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (mem_cmd_valid_o && !mem_cmd_ready_i) |=>
         (mem_cmd_valid_o && $stable(mem_cmd_write_o) && $stable(mem_cmd_addr_o) &&
          $stable(mem_cmd_data_o)))
   else
   begin
      fail_count++;
      $error("memory command changed while waiting for ready");
   end

   no_resp_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !resp_valid_o)
   else
   begin
      fail_count++;
      $error("response valid during reset");
   end

   // Engine either sends or waits, never both
   cmd_or_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(mem_cmd_valid_o && mem_resp_ready_o))
   else
   begin
      fail_count++;
      $error("command valid and response ready together");
   end

endmodule

bind dcache_replay_top dcache_replay_checker u_checker
(
   .clk_i            (clk_i),
   .rst_n_i          (rst_n_i),
   .resp_valid_o     (resp_valid_o),
   .mem_cmd_valid_o  (mem_cmd_valid_o),
   .mem_cmd_ready_i  (mem_cmd_ready_i),
   .mem_cmd_write_o  (mem_cmd_write_o),
   .mem_cmd_addr_o   (mem_cmd_addr_o),
   .mem_cmd_data_o   (mem_cmd_data_o),
   .mem_resp_ready_o (mem_resp_ready_o)
);

`default_nettype wire

// File: test/dcache_replay_tb.sv
// Random cache traffic in the low 64 words; the memory model serves one read at a time
`timescale 1ns/1ps
`default_nettype none

module dcache_replay_tb;
   import dcache_replay_pkg::*;

   localparam int NUM_RANDOM     = 300;
   localparam int NUM_DIRECTED   = 15;
   localparam int CYCLES_PER_REQ = 40;
   localparam int TIMEOUT_CYCLES = (2 * NUM_RANDOM + NUM_DIRECTED) * CYCLES_PER_REQ;
   localparam int MEM_WORDS      = 2 ** (ADDR_WIDTH - OFFSET_WIDTH);

   logic                  clk_i = 1'b0;
   logic                  rst_n_i;
   logic                  req_valid_i;
   logic                  req_ready_o;
   logic                  req_op_i;
   logic [ADDR_WIDTH-1:0] req_addr_i;
   logic [DATA_WIDTH-1:0] req_data_i;
   logic                  resp_valid_o;
   logic [DATA_WIDTH-1:0] resp_data_o;
   logic                  mem_cmd_valid_o;
   logic                  mem_cmd_ready_i;
   logic                  mem_cmd_write_o;
   logic [ADDR_WIDTH-1:0] mem_cmd_addr_o;
   logic [DATA_WIDTH-1:0] mem_cmd_data_o;
   logic                  mem_resp_valid_i;
   logic                  mem_resp_ready_o;
   logic [DATA_WIDTH-1:0] mem_resp_data_i;

   logic [DATA_WIDTH-1:0] mem_model [MEM_WORDS];
   logic [DATA_WIDTH-1:0] shadow [MEM_WORDS];
   logic [DATA_WIDTH-1:0] exp_q [$];
   cache_addr_u           wr_addr_q [$];
   logic [DATA_WIDTH-1:0] wr_data_q [$];

   logic [31:0]           stim_state = 32'hce42_4048;
   logic [31:0]           mem_state = 32'hce42_4048 ^ 32'h9e37_79b9;
   // 0 always ready, 1 random stalls and delays, 2 commands blocked
   int                    mem_mode = 0;
   int                    mem_cycle = 0;
   int                    next_delay = 0;
   logic                  rd_pending = 1'b0;
   logic [ADDR_WIDTH-1:0] rd_addr = '0;
   int                    rd_due = 0;
   int                    rd_cmds = 0;
   int                    wr_cmds = 0;
   int                    accepted = 0;
   int                    answered = 0;
   int                    checked = 0;
   int                    writes_checked = 0;
   int                    errors = 0;
   int                    cycles = 0;
   int                    cmds_before;
   logic                  saw_full;

   dcache_replay_top UUT (.*);

   always #50 clk_i = ~clk_i;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [DATA_WIDTH-1:0] init_word(input logic [ADDR_WIDTH-1:0] addr);
      return {addr ^ 16'hc3a5, ~addr, addr * 16'd7, addr ^ 16'h1e0f};
   endfunction

   // Shadow memory follows request order; stores answer zero
   function logic [DATA_WIDTH-1:0] expect_result(input logic op,
                                                 input logic [ADDR_WIDTH-1:0] addr,
                                                 input logic [DATA_WIDTH-1:0] data);
      logic [DATA_WIDTH-1:0] result;
      if (op == OP_STORE)
      begin
         shadow[addr[ADDR_WIDTH-1:OFFSET_WIDTH]] = data;
         result = '0;
      end
      else
         result = shadow[addr[ADDR_WIDTH-1:OFFSET_WIDTH]];
      return result;
   endfunction

   task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
      checked++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_write(input cache_addr_u got_addr, input logic [DATA_WIDTH-1:0] got_data);
      cache_addr_u           exp_addr;
      logic [DATA_WIDTH-1:0] exp_data;
      if (wr_addr_q.size() == 0)
      begin
         errors++;
         $display("Memory write command at %0t with no store waiting for one", $time);
      end
      else
      begin
         exp_addr = wr_addr_q.pop_front();
         exp_data = wr_data_q.pop_front();
         writes_checked++;
         if (got_addr.raw !== exp_addr.raw)
         begin
            errors++;
            $display("CHECK FAILED at %0t: mem_cmd_addr_o got %h expected %h",
                     $time, got_addr.raw, exp_addr.raw);
         end
         if (got_data !== exp_data)
         begin
            errors++;
            $display("CHECK FAILED at %0t: mem_cmd_data_o got %h expected %h",
                     $time, got_data, exp_data);
         end
      end
   endtask

   task automatic expect_count(input string what, input int got, input int exp);
      if (got != exp)
      begin
         errors++;
         $display("Expected %0d %s but the memory saw %0d", exp, what, got);
      end
   endtask

   // Called on a falling edge, returns on the falling edge after the handshake
   task automatic send_req(input logic op, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] data);
      logic taken;
      req_valid_i = 1'b1;
      req_op_i    = op;
      req_addr_i  = addr;
      req_data_i  = data;
      taken       = 1'b0;
      while (!taken)
      begin
         @(posedge clk_i);
         taken = req_ready_o;
         @(negedge clk_i);
      end
      req_valid_i = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0 || wr_addr_q.size() != 0)
         @(negedge clk_i);
   endtask

   task automatic set_mem_mode(input int mode);
      @(posedge clk_i);
      mem_mode = mode;
      @(negedge clk_i);
   endtask

   task automatic run_random(input int count);
      logic                  op;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] data;
      for (int i = 0; i < count; i++)
      begin
         stim_state = lcg_next(stim_state);
         op         = (stim_state[31:30] == 2'b11);
         addr       = '0;
         addr[8:3]  = stim_state[29:24];
         stim_state = lcg_next(stim_state);
         data[63:32] = stim_state;
         stim_state = lcg_next(stim_state);
         data[31:0] = stim_state;
         send_req(op, addr, data);
      end
      wait_drain();
   endtask

   task automatic finish_run();
      int checker_fails;
      checker_fails = UUT.u_checker.fail_count;
      if (exp_q.size() != 0 || wr_addr_q.size() != 0)
      begin
         errors++;
         $display("Run ended with %0d responses and %0d writes still expected",
                  exp_q.size(), wr_addr_q.size());
      end
      $display("Responses checked %0d, writes checked %0d, errors %0d, assertion failures %0d",
               checked, writes_checked, errors, checker_fails);
      if (errors == 0 && checker_fails == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   endtask

   // Reference update at accept, comparison at each response
   always @(posedge clk_i)
   begin
      if (rst_n_i && req_valid_i && req_ready_o)
      begin
         exp_q.push_back(expect_result(req_op_i, req_addr_i, req_data_i));
         if (req_op_i == OP_STORE)
         begin
            wr_addr_q.push_back(cache_addr_u'(req_addr_i));
            wr_data_q.push_back(req_data_i);
         end
         accepted++;
      end
      if (rst_n_i && resp_valid_o)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("Response at %0t with no request waiting for one", $time);
         end
         else
            check_word("resp_data_o", resp_data_o, exp_q.pop_front());
         answered++;
      end
      if (accepted - answered > FIFO_DEPTH)
      begin
         errors++;
         $display("At %0t there are %0d unanswered requests, more than the FIFO holds",
                  $time, accepted - answered);
      end
   end

   // Memory side handshakes
   always @(posedge clk_i)
   begin
      if (rst_n_i && mem_resp_valid_i && mem_resp_ready_o)
         rd_pending = 1'b0;
      if (rst_n_i && mem_cmd_valid_o && mem_cmd_ready_i)
      begin
         if (mem_cmd_write_o)
         begin
            check_write(cache_addr_u'(mem_cmd_addr_o), mem_cmd_data_o);
            mem_model[mem_cmd_addr_o[ADDR_WIDTH-1:OFFSET_WIDTH]] = mem_cmd_data_o;
            wr_cmds++;
         end
         else
         begin
            rd_cmds++;
            rd_pending = 1'b1;
            rd_addr    = mem_cmd_addr_o;
            rd_due     = mem_cycle + next_delay;
         end
      end
   end

   always @(negedge clk_i)
   begin
      mem_cycle++;
      mem_state  = lcg_next(mem_state);
      next_delay = (mem_mode == 1) ? int'(mem_state[29:27]) : 0;
      case (mem_mode)
         0:       mem_cmd_ready_i = 1'b1;
         1:       mem_cmd_ready_i = (mem_state[31:30] != 2'b00);
         default: mem_cmd_ready_i = 1'b0;
      endcase
      mem_resp_valid_i = rd_pending && (mem_cycle > rd_due);
      mem_resp_data_i  = rd_pending ? mem_model[rd_addr[ADDR_WIDTH-1:OFFSET_WIDTH]] : '0;
   end

   always @(posedge clk_i)
   begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles with %0d requests unanswered",
                  cycles, accepted - answered);
         $display("Checks failed");
         $finish;
      end
   end

   initial
   begin
      rst_n_i          = 1'b0;
      req_valid_i      = 1'b0;
      req_op_i         = OP_LOAD;
      req_addr_i       = '0;
      req_data_i       = '0;
      mem_cmd_ready_i  = 1'b0;
      mem_resp_valid_i = 1'b0;
      mem_resp_data_i  = '0;
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         mem_model[i] = init_word(ADDR_WIDTH'(i << OFFSET_WIDTH));
         shadow[i]    = mem_model[i];
      end
      repeat (5) @(negedge clk_i);
      rst_n_i = 1'b1;

      // Miss then hit on the same line
      cmds_before = rd_cmds;
      send_req(OP_LOAD, 16'h0040, '0);
      wait_drain();
      expect_count("reads after the first load", rd_cmds - cmds_before, 1);
      send_req(OP_LOAD, 16'h0040, '0);
      wait_drain();
      expect_count("reads after the repeat load", rd_cmds - cmds_before, 1);

      // Store hit and store miss, then read both back
      cmds_before = wr_cmds;
      send_req(OP_STORE, 16'h0040, 64'h0123_4567_89ab_cdef);
      send_req(OP_STORE, 16'h0048, 64'hfedc_ba98_7654_3210);
      wait_drain();
      expect_count("writes after two stores", wr_cmds - cmds_before, 2);
      send_req(OP_LOAD, 16'h0040, '0);
      send_req(OP_LOAD, 16'h0048, '0);
      wait_drain();

      run_random(NUM_RANDOM);
      set_mem_mode(1);
      run_random(NUM_RANDOM);

      // Blocked memory commands fill the FIFO
      set_mem_mode(2);
      for (int i = 0; i <= FIFO_DEPTH; i++)
         send_req(OP_STORE, ADDR_WIDTH'((i + 16) << OFFSET_WIDTH), 64'hfeed_0000_0000_0000 | i);
      saw_full = 1'b0;
      repeat (4)
      begin
         @(negedge clk_i);
         if (!req_ready_o)
            saw_full = 1'b1;
      end
      if (!saw_full)
      begin
         errors++;
         $display("req_ready_o stayed high while memory commands were blocked");
      end
      set_mem_mode(0);
      wait_drain();
      finish_run();
   end

endmodule

`default_nettype wire
